// ==== design/cordic_defs.svh ====
//----------------------------------------
// cordic widths and iteration counts
// shared by the packages and the rotator
//----------------------------------------

`ifndef CORDIC_DEFS_SVH
`define CORDIC_DEFS_SVH

// input sample width, signed
`define CORDIC_IN_W         17

// internal width, one bit over the input for the cordic gain
`define CORDIC_ACC_W        18

// output sample width after truncation
`define CORDIC_OUT_W        16

// angle width, 4095 is 45 degrees, msb is the sign
`define CORDIC_ANGLE_W      15

// micro-rotations, two per pipeline stage
`define CORDIC_ITERS        13
`define CORDIC_NUM_STAGES   7

`endif

// ==== design/cordic_data_pkg.sv ====
//----------------------------------------
// cordic I/Q sample types
//----------------------------------------

`default_nettype none

`include "cordic_defs.svh"

package cordic_data_pkg;

    // sample as it enters the rotator
    typedef logic signed [`CORDIC_IN_W-1:0]  in_sample_t;

    // working width inside the pipeline
    typedef logic signed [`CORDIC_ACC_W-1:0] acc_t;

    // truncated result
    typedef logic signed [`CORDIC_OUT_W-1:0] out_sample_t;

endpackage

`default_nettype wire

// ==== design/cordic_angle_pkg.sv ====
//----------------------------------------
// cordic angle type and arctangent table
// angle units: 4095 equals 45 degrees
//----------------------------------------

`default_nettype none

`include "cordic_defs.svh"

package cordic_angle_pkg;

    // residual angle, two's complement
    typedef logic signed [`CORDIC_ANGLE_W-1:0] angle_t;

    // atan(2^-k) in angle units, indexed by iteration k
    // last entry kept for completeness, the final iteration drops the angle
    localparam angle_t atan_table [0:`CORDIC_ITERS-1] = '{
        15'sd4095,
        15'sd2418,
        15'sd1277,
        15'sd648,
        15'sd325,
        15'sd162,
        15'sd81,
        15'sd40,
        15'sd20,
        15'sd10,
        15'sd5,
        15'sd2,
        15'sd1
    };

endpackage

`default_nettype wire

// ==== design/cordic_micro_rotation.sv ====
//----------------------------------------
// cordic micro-rotation
// one shift-and-add iteration, direction from the angle sign
//----------------------------------------

`default_nettype none

`include "cordic_defs.svh"

module cordic_micro_rotation
    import cordic_data_pkg::*;
    import cordic_angle_pkg::*;
#(
    // iteration index, 0 to 12
    parameter int unsigned ITER = 0
)
(
    input  acc_t   i_i,
    input  acc_t   q_i,
    input  angle_t angle_i,
    output acc_t   i_o,
    output acc_t   q_o,
    output angle_t angle_o
);

    acc_t   i_shift;
    acc_t   q_shift;
    angle_t atan_k;
    logic   angle_neg;

    // arithmetic shift keeps the sign of each coordinate
    assign i_shift   = i_i >>> ITER;
    assign q_shift   = q_i >>> ITER;
    assign atan_k    = atan_table[ITER];
    assign angle_neg = angle_i[`CORDIC_ANGLE_W-1];

    // all sums wrap in their own width
    always_comb
    begin
        if (angle_neg)
        begin
            i_o     = i_i - q_shift;
            q_o     = q_i + i_shift;
            angle_o = angle_i + atan_k;
        end
        else
        begin
            i_o     = i_i + q_shift;
            q_o     = q_i - i_shift;
            angle_o = angle_i - atan_k;
        end
    end

endmodule

`default_nettype wire

// ==== design/cordic_stage.sv ====
//----------------------------------------
// cordic pipeline stage
// chained micro-rotations into a run-enabled register
//----------------------------------------

`default_nettype none

module cordic_stage
    import cordic_data_pkg::*;
    import cordic_angle_pkg::*;
#(
    // iteration index of the first micro-rotation
    parameter int unsigned FIRST_ITER = 0,
    // micro-rotations in this stage, 1 or 2
    parameter int unsigned NUM_ITERS  = 2
)
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   run_i,
    input  acc_t   i_i,
    input  acc_t   q_i,
    input  angle_t angle_i,
    output acc_t   i_o,
    output acc_t   q_o,
    output angle_t angle_o
);

    // ----------------------------------------
    // combinational chain
    // ----------------------------------------

    // entry 0 is the stage input, entry NUM_ITERS feeds the register
    acc_t   i_chain     [NUM_ITERS+1];
    acc_t   q_chain     [NUM_ITERS+1];
    angle_t angle_chain [NUM_ITERS+1];

    assign i_chain[0]     = i_i;
    assign q_chain[0]     = q_i;
    assign angle_chain[0] = angle_i;

    for (genvar n = 0; n < NUM_ITERS; n++)
    begin : g_iter
        cordic_micro_rotation #(
            .ITER    (FIRST_ITER + n)
        ) u_micro_rotation (
            .i_i     (i_chain[n]),
            .q_i     (q_chain[n]),
            .angle_i (angle_chain[n]),
            .i_o     (i_chain[n+1]),
            .q_o     (q_chain[n+1]),
            .angle_o (angle_chain[n+1])
        );
    end

    // ----------------------------------------
    // pipeline register
    // ----------------------------------------

    // holds everything while run_i is low
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            i_o     <= '0;
            q_o     <= '0;
            angle_o <= '0;
        end
        else if (run_i)
        begin
            i_o     <= i_chain[NUM_ITERS];
            q_o     <= q_chain[NUM_ITERS];
            angle_o <= angle_chain[NUM_ITERS];
        end
    end

endmodule

`default_nettype wire

// ==== design/cordic_rotator.sv ====
//----------------------------------------
// pipelined cordic vector rotator
// 13 micro-rotations over 7 stages, no gain correction
//----------------------------------------

`default_nettype none

`include "cordic_defs.svh"

module cordic_rotator
    import cordic_data_pkg::*;
    import cordic_angle_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        run_i,
    input  in_sample_t  i_data_i,
    input  in_sample_t  q_data_i,
    input  angle_t      angle_i,
    output out_sample_t i_data_o,
    output out_sample_t q_data_o
);

    // stage_i[s] feeds stage s, the last entry is the final result
    acc_t   stage_i     [`CORDIC_NUM_STAGES+1];
    acc_t   stage_q     [`CORDIC_NUM_STAGES+1];
    angle_t stage_angle [`CORDIC_NUM_STAGES];

    // signed assignment sign-extends into the wider accumulator
    assign stage_i[0]     = i_data_i;
    assign stage_q[0]     = q_data_i;
    assign stage_angle[0] = angle_i;

    // ----------------------------------------
    // two micro-rotations per stage
    // ----------------------------------------
    for (genvar s = 0; s < `CORDIC_NUM_STAGES - 1; s++)
    begin : g_stage
        cordic_stage #(
            .FIRST_ITER (2 * s),
            .NUM_ITERS  (2)
        ) u_stage (
            .clk        (clk),
            .rst_n      (rst_n),
            .run_i      (run_i),
            .i_i        (stage_i[s]),
            .q_i        (stage_q[s]),
            .angle_i    (stage_angle[s]),
            .i_o        (stage_i[s+1]),
            .q_o        (stage_q[s+1]),
            .angle_o    (stage_angle[s+1])
        );
    end

    // last stage runs the leftover iteration, its angle goes nowhere
    cordic_stage #(
        .FIRST_ITER (2 * (`CORDIC_NUM_STAGES - 1)),
        .NUM_ITERS  (`CORDIC_ITERS - 2 * (`CORDIC_NUM_STAGES - 1))
    ) u_stage_last (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_i      (run_i),
        .i_i        (stage_i[`CORDIC_NUM_STAGES-1]),
        .q_i        (stage_q[`CORDIC_NUM_STAGES-1]),
        .angle_i    (stage_angle[`CORDIC_NUM_STAGES-1]),
        .i_o        (stage_i[`CORDIC_NUM_STAGES]),
        .q_o        (stage_q[`CORDIC_NUM_STAGES]),
        .angle_o    ()
    );

    // plain truncation to the low bits, gain of about 1.647 stays in
    assign i_data_o = stage_i[`CORDIC_NUM_STAGES][`CORDIC_OUT_W-1:0];
    assign q_data_o = stage_q[`CORDIC_NUM_STAGES][`CORDIC_OUT_W-1:0];

endmodule

`default_nettype wire

// ==== sim/tb_cordic_rotator.sv ====
//----------------------------------------
// cordic rotator testbench
// replays the vector file single, streamed and paused
//----------------------------------------

`default_nettype none

`include "cordic_defs.svh"

module tb_cordic_rotator
    import cordic_data_pkg::*;
    import cordic_angle_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_VEC    = 7;
    localparam int LATENCY    = `CORDIC_NUM_STAGES;
    // reset, single vectors with drain, stream, paused stream, margin
    localparam int CYCLE_LIMIT = 3 + NUM_VEC * (1 + LATENCY) + (NUM_VEC + LATENCY)
                               + (NUM_VEC * 4 + LATENCY) + 50;

    // one entry per run-enabled edge
    // valid marks a real vector
    typedef struct packed
    {
        logic        valid;
        out_sample_t i;
        out_sample_t q;
    } slot_t;

    logic        clk;
    logic        rst_n;
    logic        run;
    in_sample_t  i_in;
    in_sample_t  q_in;
    angle_t      angle_in;
    out_sample_t i_out;
    out_sample_t q_out;

    // angle, i, q, expected i, expected q per vector
    logic [31:0] vec_mem [0:NUM_VEC*5-1];

    slot_t       slots [$];
    slot_t       incoming;
    slot_t       head;
    logic        feed_valid;
    out_sample_t feed_i;
    out_sample_t feed_q;
    logic        check_due;
    logic        hold_due;
    out_sample_t due_i;
    out_sample_t due_q;
    out_sample_t held_i;
    out_sample_t held_q;

    int results_out;
    int value_errors;
    int hold_errors;
    int other_errors;
    int cycle_count;
    int seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cordic_rotator u_cordic_rotator (
        .clk      (clk),
        .rst_n    (rst_n),
        .run_i    (run),
        .i_data_i (i_in),
        .q_data_i (q_in),
        .angle_i  (angle_in),
        .i_data_o (i_out),
        .q_data_o (q_out)
    );

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_sample(input string name, input out_sample_t got,
                                input out_sample_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("ERROR at %0t: %s got %0d (0x%h), expected %0d (0x%h)",
                     $time, name, got, got, exp, exp);
        end
    endtask

    task automatic check_hold(input string name, input out_sample_t got,
                              input out_sample_t held);
        if (got !== held)
        begin
            hold_errors++;
            $display("ERROR at %0t: %s moved while run was low, got %0d, held %0d",
                     $time, name, got, held);
        end
    endtask

    // ----------------------------------------
    // stimulus driven on the falling edge
    // ----------------------------------------

    task automatic apply_vector(input int idx);
        int base;
        base = idx * 5;
        @(negedge clk);
        run        = 1'b1;
        angle_in   = vec_mem[base][`CORDIC_ANGLE_W-1:0];
        i_in       = vec_mem[base+1][`CORDIC_IN_W-1:0];
        q_in       = vec_mem[base+2][`CORDIC_IN_W-1:0];
        feed_valid = 1'b1;
        feed_i     = vec_mem[base+3][`CORDIC_OUT_W-1:0];
        feed_q     = vec_mem[base+4][`CORDIC_OUT_W-1:0];
    endtask

    // scramble puts junk on the inputs, which a paused DUT must ignore
    task automatic apply_idle(input logic run_level, input logic scramble);
        @(negedge clk);
        run        = run_level;
        feed_valid = 1'b0;
        if (scramble)
        begin
            i_in     = in_sample_t'($random(seed));
            q_in     = in_sample_t'($random(seed));
            angle_in = angle_t'($random(seed));
        end
        else
        begin
            i_in     = '0;
            q_in     = '0;
            angle_in = '0;
        end
    endtask

    task automatic wait_results(input int target);
        while (results_out < target)
        begin
            apply_idle(1'b1, 1'b0);
        end
    endtask

    // ----------------------------------------
    // expected model that advances on run edges
    // ----------------------------------------

    always @(posedge clk)
    begin
        check_due = 1'b0;
        hold_due  = 1'b0;
        if (!rst_n)
        begin
            slots.delete();
        end
        else if (run)
        begin
            incoming.valid = feed_valid;
            incoming.i     = feed_i;
            incoming.q     = feed_q;
            slots.push_back(incoming);
            // seventh run edge since capture puts the result on the outputs
            if (slots.size() == LATENCY)
            begin
                head = slots.pop_front();
                if (head.valid)
                begin
                    check_due = 1'b1;
                    due_i     = head.i;
                    due_q     = head.q;
                    results_out++;
                end
            end
        end
        else
        begin
            hold_due = 1'b1;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (hold_due)
        begin
            check_hold("i_data_o", i_out, held_i);
            check_hold("q_data_o", q_out, held_q);
        end
        if (check_due)
        begin
            check_sample("i_data_o", i_out, due_i);
            check_sample("q_data_o", q_out, due_q);
        end
        held_i = i_out;
        held_q = q_out;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: no end of test after %0d cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial
    begin
        int pause;
        clk           = 1'b0;
        rst_n         = 1'b0;
        run           = 1'b0;
        i_in          = '0;
        q_in          = '0;
        angle_in      = '0;
        feed_valid    = 1'b0;
        feed_i        = '0;
        feed_q        = '0;
        check_due     = 1'b0;
        hold_due      = 1'b0;
        held_i        = '0;
        held_q        = '0;
        results_out   = 0;
        value_errors  = 0;
        hold_errors   = 0;
        other_errors  = 0;
        cycle_count   = 0;
        seed          = 32'h12ad5b00;

        $readmemh("sim/cordic_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*5-1]))
        begin
            $display("vector file sim/cordic_vectors.txt is missing or too short");
            other_errors++;
        end

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // registers still cleared with no run edge yet
        apply_idle(1'b0, 1'b0);
        check_sample("i_data_o", i_out, '0);
        check_sample("q_data_o", q_out, '0);

        if (other_errors == 0)
        begin
            // one vector at a time with the result drained in between
            for (int v = 0; v < NUM_VEC; v++)
            begin
                apply_vector(v);
                wait_results(v + 1);
            end

            // back to back with seven in flight
            for (int v = 0; v < NUM_VEC; v++)
            begin
                apply_vector(v);
            end
            wait_results(2 * NUM_VEC);

            // random run pauses of up to 3 cycles
            for (int v = 0; v < NUM_VEC; v++)
            begin
                pause = $unsigned($random(seed)) % 4;
                repeat (pause) apply_idle(1'b0, 1'b1);
                apply_vector(v);
            end
            wait_results(3 * NUM_VEC);
            @(posedge clk);
        end

        $display("errors: %0d value, %0d hold, %0d other", value_errors, hold_errors,
                 other_errors);
        if (value_errors + hold_errors + other_errors == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/cordic_vectors.txt ====
// cordic rotator vectors, all values hex, two's complement
// columns: angle (15b), i in (17b), q in (17b), expected i out (16b), expected q out (16b)

// angle zero, vector on the i axis
0000 003E8 00000 0671 0000

// +45 and -45 degrees
0FFF 003E8 00000 048D FB74
7001 003E8 00000 048C 048D

// close to the +90 and -90 degree limit, mixed sign inputs
1FFE 00BB8 1F830 F322 ECB6
6002 1EC78 00FA0 E647 DFD5

// other angles, both inputs negative, then a large input
07D0 1FA24 1F63C F10B F4B0
7448 02EE0 01B58 2844 4FC8

// ==== compile.f ====
+incdir+design
design/cordic_data_pkg.sv
design/cordic_angle_pkg.sv
design/cordic_micro_rotation.sv
design/cordic_stage.sv
design/cordic_rotator.sv
sim/tb_cordic_rotator.sv

// ==== Bender.yml ====
package:
  name: cordic_rotator

sources:
  - include_dirs:
      - design
    files:
      - design/cordic_data_pkg.sv
      - design/cordic_angle_pkg.sv
      - design/cordic_micro_rotation.sv
      - design/cordic_stage.sv
      - design/cordic_rotator.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_cordic_rotator.sv
